//--- source/spw_rx_pkg.sv
// Shared character codes and types for the SpaceWire link receiver
// Imported by the assembler, the classifier and the top level
`default_nettype none

package spw_rx_pkg;

	// --------------------------------------------------
	// Character lengths, parity and flag bits included
	// --------------------------------------------------
	localparam int CTRL_LEN = 4;
	localparam int DATA_LEN = 10;
	localparam int CNT_W    = $clog2(DATA_LEN);	// Bit counter width

	// Control codes, first received bit is the LSB
	localparam logic [1:0] CODE_FCT = 2'd0;
	localparam logic [1:0] CODE_EOP = 2'd1;
	localparam logic [1:0] CODE_EEP = 2'd2;
	localparam logic [1:0] CODE_ESC = 2'd3;

	// Data byte reported with flag set
	localparam logic [7:0] EOP_DATA = 8'h00;
	localparam logic [7:0] EEP_DATA = 8'h01;

	// --------------------------------------------------
	// Received word, two views of the same 10 bits
	// --------------------------------------------------
	typedef struct packed {
		logic [7:0] data;	// Data byte, LSB received first
		logic       flag;	// 0 for data
		logic       parity;	// First bit on the line
	} spw_data_view_t;

	typedef struct packed {
		logic [5:0] unused;	// Always zero for control chars
		logic [1:0] ctrl;
		logic       flag;	// 1 for control
		logic       parity;
	} spw_ctrl_view_t;

	typedef union packed {
		spw_data_view_t data_v;
		spw_ctrl_view_t ctrl_v;
	} spw_char_u;

	// Assembler to classifier
	typedef struct packed {
		logic      is_ctrl;
		spw_char_u body;
	} spw_char_t;

	// Normal character as handed to the buffer
	typedef struct packed {
		logic       flag;	// Set for EOP and EEP
		logic [7:0] data;
	} spw_nchar_t;

endpackage

`default_nettype wire

//--- source/spw_ds_decoder.sv
// Data-strobe bit recovery by oversampling on the system clock
// One bit_valid pulse per change of D xor S, value taken from D
`default_nettype none

module spw_ds_decoder
(
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_valid,
	output logic bit_value,
	output logic line_active
);

	// --------------------------------------------------
	// Input synchronizers
	// --------------------------------------------------
	logic [1:0] d_sync;	// [1] is the stable copy
	logic [1:0] s_sync;
	logic       ds_prev;	// D xor S seen last cycle
	logic       ds_now;
	logic       ds_edge;

	assign ds_now  = d_sync[1] ^ s_sync[1];
	assign ds_edge = ds_now ^ ds_prev;	// Any D or S transition

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_sync <= 2'b00;	// Idle line is D=S=0
			s_sync <= 2'b00;
		end
		else
		begin
			d_sync <= {d_sync[0], rx_din};
			s_sync <= {s_sync[0], rx_sin};
		end
	end

	// --------------------------------------------------
	// Transition compare, third edge after the line change
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			ds_prev     <= 1'b0;
			bit_valid   <= 1'b0;
			bit_value   <= 1'b0;
			line_active <= 1'b0;
		end
		else
		begin
			ds_prev   <= ds_now;
			bit_valid <= ds_edge;	// One cycle strobe
			bit_value <= d_sync[1];
			if (ds_edge)
				line_active <= 1'b1;	// Sticky until reset
		end
	end

endmodule

`default_nettype wire

//--- source/spw_char_assembler.sv
// Collects recovered bits into control or data characters
// Length follows the flag bit and parity runs across character boundaries
`default_nettype none

module spw_char_assembler
(
	input  logic                  posedge_clk,
	input  logic                  rx_resetn,
	input  logic                  bit_valid,
	input  logic                  bit_value,
	output logic                  char_valid,
	output spw_rx_pkg::spw_char_t char_word,
	output logic                  parity_err
);

	import spw_rx_pkg::*;

	logic [CNT_W-1:0] bit_cnt;	// Index of the incoming bit
	logic [CNT_W-1:0] char_len;	// Target length set at the flag bit
	spw_char_u        shreg;
	spw_char_u        word_next;	// Word including the incoming bit
	logic             is_ctrl;
	logic             last_bit;
	logic             payload_par;	// Parity of data or ctrl bits
	logic             prev_par;	// Payload parity of the previous char

	// --------------------------------------------------
	// Next word and end of character
	// --------------------------------------------------
	always_comb
	begin
		if (bit_cnt == '0)
			word_next = '0;	// Fresh character starts from zero
		else
			word_next = shreg;
		word_next[bit_cnt] = bit_value;	// LSB first
	end

	assign is_ctrl = word_next.data_v.flag;

	// Length is 4 or 10, so the end never falls on bit 0 or 1
	assign last_bit = bit_valid && (bit_cnt == char_len - 1'b1);

	always_comb
	begin
		if (is_ctrl)
			payload_par = ^word_next.ctrl_v.ctrl;
		else
			payload_par = ^word_next.data_v.data;
	end

	// --------------------------------------------------
	// Counter, strobes and parity state
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_cnt    <= '0;
			char_len   <= CNT_W'(DATA_LEN);
			char_valid <= 1'b0;
			parity_err <= 1'b0;
			prev_par   <= 1'b0;	// No previous char after reset
		end
		else
		begin
			char_valid <= 1'b0;
			parity_err <= 1'b0;
			if (bit_valid)
			begin
				if (bit_cnt == CNT_W'(1))	// Flag bit arriving
					char_len <= is_ctrl ? CNT_W'(CTRL_LEN) : CNT_W'(DATA_LEN);
				if (last_bit)
				begin
					bit_cnt    <= '0;
					char_valid <= 1'b1;
					// Parity + flag + previous payload must be odd
					parity_err <= ~(word_next.data_v.parity ^ is_ctrl ^ prev_par);
					prev_par   <= payload_par;
				end
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Shift register and output word
	always_ff @(posedge posedge_clk)
	begin
		if (bit_valid)
			shreg <= word_next;
		if (last_bit)
		begin
			char_word.is_ctrl <= is_ctrl;
			char_word.body    <= word_next;
		end
	end

endmodule

`default_nettype wire

//--- source/spw_char_classifier.sv
// Turns assembled characters into link events
// Escape handling, NULL gating, output strobes and the sticky error flag
`default_nettype none

module spw_char_classifier
(
	input  logic                   posedge_clk,
	input  logic                   rx_resetn,
	input  logic                   char_valid,
	input  spw_rx_pkg::spw_char_t  char_word,
	input  logic                   parity_err,
	output logic                   rx_got_null,
	output logic                   rx_got_fct,
	output logic                   rx_got_nchar,
	output logic                   rx_got_time_code,
	output logic                   rx_buffer_write,
	output spw_rx_pkg::spw_nchar_t rx_data_flag,
	output logic [7:0]             rx_time_out,
	output logic                   rx_tick_out,
	output logic                   rx_error
);

	import spw_rx_pkg::*;

	logic       esc_pend;	// Last char was ESC
	logic [1:0] code;
	logic [7:0] data;
	logic       take;	// Character is looked at

	assign code = char_word.body.ctrl_v.ctrl;
	assign data = char_word.body.data_v.data;
	assign take = char_valid && !rx_error;	// Everything dropped after an error

	// --------------------------------------------------
	// Event decode
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			esc_pend         <= 1'b0;
			rx_got_null      <= 1'b0;
			rx_error         <= 1'b0;
			rx_got_fct       <= 1'b0;
			rx_got_nchar     <= 1'b0;
			rx_got_time_code <= 1'b0;
			rx_buffer_write  <= 1'b0;
			rx_tick_out      <= 1'b0;
			rx_time_out      <= 8'h00;
		end
		else
		begin
			// Strobes last one cycle
			rx_got_fct       <= 1'b0;
			rx_got_nchar     <= 1'b0;
			rx_got_time_code <= 1'b0;
			rx_buffer_write  <= 1'b0;
			rx_tick_out      <= 1'b0;
			if (take && parity_err)
			begin
				rx_error <= 1'b1;
				esc_pend <= 1'b0;
			end
			else if (take && char_word.is_ctrl)
			begin
				if (esc_pend)
				begin
					esc_pend <= 1'b0;
					if (code == CODE_FCT)
						rx_got_null <= 1'b1;	// ESC FCT
					else
						rx_error <= 1'b1;	// ESC ESC, ESC EOP, ESC EEP
				end
				else if (code == CODE_ESC)
					esc_pend <= 1'b1;
				else if (rx_got_null)
				begin
					if (code == CODE_FCT)
						rx_got_fct <= 1'b1;
					else
					begin
						rx_got_nchar    <= 1'b1;	// EOP or EEP
						rx_buffer_write <= 1'b1;
					end
				end
			end
			else if (take)
			begin
				esc_pend <= 1'b0;
				if (rx_got_null && esc_pend)
				begin
					rx_time_out      <= data;	// Time code
					rx_tick_out      <= 1'b1;
					rx_got_time_code <= 1'b1;
				end
				else if (rx_got_null)
				begin
					rx_got_nchar    <= 1'b1;
					rx_buffer_write <= 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// Buffer word, only meaningful with rx_buffer_write
	// --------------------------------------------------
	always_ff @(posedge posedge_clk)
	begin
		if (take && !char_word.is_ctrl)
			rx_data_flag <= '{flag: 1'b0, data: data};
		else if (take && code == CODE_EOP)
			rx_data_flag <= '{flag: 1'b1, data: EOP_DATA};
		else if (take && code == CODE_EEP)
			rx_data_flag <= '{flag: 1'b1, data: EEP_DATA};
	end

endmodule

`default_nettype wire

//--- source/spw_rx.sv
// SpaceWire receiver top, single clock and asynchronous reset
// Chain of bit decoder, character assembler and character classifier
`default_nettype none

module spw_rx
(
	input  logic                   posedge_clk,
	input  logic                   rx_resetn,
	input  logic                   rx_din,
	input  logic                   rx_sin,
	output logic                   rx_got_bit,	// Line has toggled
	output logic                   rx_got_null,
	output logic                   rx_got_fct,
	output logic                   rx_got_nchar,
	output logic                   rx_got_time_code,
	output logic                   rx_buffer_write,
	output spw_rx_pkg::spw_nchar_t rx_data_flag,
	output logic [7:0]             rx_time_out,
	output logic                   rx_tick_out,
	output logic                   rx_error
);

	import spw_rx_pkg::*;

	logic      bit_valid;
	logic      bit_value;
	logic      char_valid;
	spw_char_t char_word;
	logic      parity_err;

	// --------------------------------------------------
	// Bit recovery
	// --------------------------------------------------
	spw_ds_decoder i_ds_decoder
	(
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.line_active (rx_got_bit)
	);

	// Character framing and parity
	spw_char_assembler i_char_assembler
	(
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.char_valid  (char_valid),
		.char_word   (char_word),
		.parity_err  (parity_err)
	);

	// Link events
	spw_char_classifier i_char_classifier
	(
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.char_valid       (char_valid),
		.char_word        (char_word),
		.parity_err       (parity_err),
		.rx_got_null      (rx_got_null),
		.rx_got_fct       (rx_got_fct),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_buffer_write  (rx_buffer_write),
		.rx_data_flag     (rx_data_flag),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out),
		.rx_error         (rx_error)
	);

endmodule

`default_nettype wire

//--- dv/spw_clk_gen.sv
// Free running testbench clock, starts low
// PERIOD sets the full cycle in time units
`default_nettype none

module spw_clk_gen
#(
	parameter int PERIOD = 40
)
(
	output logic clk
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;	// 50 % duty

endmodule

`default_nettype wire

//--- dv/tb_spw_rx.sv
// Testbench for the SpaceWire receiver driving D/S from encoder tasks
// Expected events come from a reference model and are compared as they appear
`default_nettype none

module tb_spw_rx;

	import spw_rx_pkg::*;

	localparam int          CLK_PERIOD = 40;
	localparam int          RESET_CLKS = 16;
	localparam int          BIT_CLKS   = 6;	// Clocks per line bit
	localparam int          DRIVE_DLY  = 2;	// After the rising edge
	localparam int          DRAIN_CLKS = 40;
	localparam int          NUM_BYTES  = 40;
	localparam int          NUM_TICKS  = 8;
	localparam int          MAX_CHARS  = 30 + NUM_BYTES + NUM_BYTES / 8 + 2 * NUM_TICKS;
	localparam longint      WATCHDOG_TIME = longint'(MAX_CHARS) * DATA_LEN * BIT_CLKS *
	                                        CLK_PERIOD * 2 + 3 * RESET_CLKS * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hb20eb838;

	// Event kinds of the reference model
	localparam logic [2:0] EV_NONE  = 3'd0;
	localparam logic [2:0] EV_FCT   = 3'd1;
	localparam logic [2:0] EV_NCHAR = 3'd2;
	localparam logic [2:0] EV_TIME  = 3'd3;
	localparam logic [2:0] EV_ERROR = 3'd4;

	typedef struct packed {
		logic esc;	// ESC seen and waiting for the next char
		logic got_null;
		logic err;
	} ref_state_t;

	typedef struct packed {
		logic [2:0] kind;
		logic [8:0] value;	// nchar word or time code
	} exp_event_t;

	typedef struct packed {
		ref_state_t st;	// State after the character
		exp_event_t ev;
	} ref_result_t;

	logic        posedge_clk;
	logic        rx_resetn;
	logic        rx_din;
	logic        rx_sin;
	logic        rx_got_bit;
	logic        rx_got_null;
	logic        rx_got_fct;
	logic        rx_got_nchar;
	logic        rx_got_time_code;
	logic        rx_buffer_write;
	spw_nchar_t  rx_data_flag;
	logic [7:0]  rx_time_out;
	logic        rx_tick_out;
	logic        rx_error;

	exp_event_t  expect_q[$];	// Events still to come from the DUT
	ref_state_t  ref_st;
	logic        tx_prev_par;	// Payload parity of the last sent char
	logic        err_seen;	// rx_error at the previous negedge
	logic [31:0] rng;

	spw_clk_gen #(.PERIOD(CLK_PERIOD)) i_clk_gen (.clk(posedge_clk));

	spw_rx i_spw_rx
	(
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.rx_din           (rx_din),
		.rx_sin           (rx_sin),
		.rx_got_bit       (rx_got_bit),
		.rx_got_null      (rx_got_null),
		.rx_got_fct       (rx_got_fct),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_buffer_write  (rx_buffer_write),
		.rx_data_flag     (rx_data_flag),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out),
		.rx_error         (rx_error)
	);

	// --------------------------------------------------
	// Failure reporting and the single compare
	// --------------------------------------------------
	task automatic stop_failed();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			stop_failed();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------------------------------------
	// Reference model for one character at a time
	// --------------------------------------------------
	function automatic ref_result_t expect_event(input ref_state_t st, input logic is_ctrl,
			input logic [7:0] payload, input logic bad_parity);
		ref_result_t res;
		logic        esc_was;
		res      = '0;
		res.st   = st;
		esc_was  = st.esc;
		if (st.err)
			res.ev.kind = EV_NONE;	// Dead until reset
		else if (bad_parity)
		begin
			res.st.err  = 1'b1;
			res.st.esc  = 1'b0;
			res.ev.kind = EV_ERROR;
		end
		else if (is_ctrl && esc_was)
		begin
			res.st.esc = 1'b0;
			if (payload[1:0] == CODE_FCT)
				res.st.got_null = 1'b1;	// NULL
			else
			begin
				res.st.err  = 1'b1;	// Escape error
				res.ev.kind = EV_ERROR;
			end
		end
		else if (is_ctrl && payload[1:0] == CODE_ESC)
			res.st.esc = 1'b1;
		else if (is_ctrl && st.got_null)
		begin
			if (payload[1:0] == CODE_FCT)
				res.ev.kind = EV_FCT;
			else
			begin
				res.ev.kind  = EV_NCHAR;
				res.ev.value = {1'b1, (payload[1:0] == CODE_EOP) ? EOP_DATA : EEP_DATA};
			end
		end
		else if (!is_ctrl)
		begin
			res.st.esc = 1'b0;
			if (st.got_null)
			begin
				res.ev.kind  = esc_was ? EV_TIME : EV_NCHAR;	// ESC + data is a time code
				res.ev.value = {1'b0, payload};
			end
		end
		return res;
	endfunction

	// --------------------------------------------------
	// D/S encoder
	// --------------------------------------------------
	task automatic drive_bit(input logic value);
		@(posedge posedge_clk);
		#(DRIVE_DLY);
		if (value != rx_din)
			rx_din = value;
		else
			rx_sin = ~rx_sin;	// Strobe toggles when D holds
		repeat (BIT_CLKS - 1) @(posedge posedge_clk);
	endtask

	task automatic send_char(input logic is_ctrl, input logic [7:0] payload,
			input logic flip_parity);
		ref_result_t res;
		int          n_bits;
		res    = expect_event(ref_st, is_ctrl, payload, flip_parity);
		ref_st = res.st;
		if (res.ev.kind != EV_NONE)
			expect_q.push_back(res.ev);	// Queued before the first bit
		n_bits = is_ctrl ? 2 : 8;
		drive_bit(~(is_ctrl ^ tx_prev_par) ^ flip_parity);	// Odd parity
		drive_bit(is_ctrl);
		for (int i = 0; i < n_bits; i++)
			drive_bit(payload[i]);
		tx_prev_par = is_ctrl ? ^payload[1:0] : ^payload;
	endtask

	task automatic send_ctrl(input logic [1:0] code);
		send_char(1'b1, {6'd0, code}, 1'b0);
	endtask

	task automatic send_random_data();
		rng = xorshift32(rng);
		send_char(1'b0, rng[7:0], 1'b0);
	endtask

	task automatic send_null();
		send_ctrl(CODE_ESC);
		send_ctrl(CODE_FCT);
	endtask

	task automatic send_random_time();
		send_ctrl(CODE_ESC);
		send_random_data();
	endtask

	// --------------------------------------------------
	// Reset and settling
	// --------------------------------------------------
	task automatic apply_reset();
		@(posedge posedge_clk);
		#(DRIVE_DLY);
		rx_resetn   = 1'b0;
		rx_din      = 1'b0;	// Idle line
		rx_sin      = 1'b0;
		tx_prev_par = 1'b0;
		ref_st      = '0;
		expect_q.delete();
		repeat (RESET_CLKS) @(posedge posedge_clk);
		#(DRIVE_DLY);
		rx_resetn = 1'b1;
	endtask

	// Wait for all queued events within a bound
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < DRAIN_CLKS)
		begin
			@(negedge posedge_clk);
			waited++;
		end
		repeat (2) @(negedge posedge_clk);
		check_value(expect_q.size(), 0, "number of missing DUT events");
	endtask

	// --------------------------------------------------
	// Compare process sampling at the falling edge
	// --------------------------------------------------
	task automatic compare_event(input logic err_rise);
		exp_event_t ev;
		if (expect_q.size() == 0)
		begin
			$display("The DUT reported an event at %0t that no sent character explains",
			         $time);
			stop_failed();
		end
		else
		begin
			ev = expect_q.pop_front();
			check_value(rx_got_fct, ev.kind == EV_FCT, "rx_got_fct");
			check_value(rx_got_nchar, ev.kind == EV_NCHAR, "rx_got_nchar");
			check_value(rx_buffer_write, ev.kind == EV_NCHAR, "rx_buffer_write");
			check_value(rx_got_time_code, ev.kind == EV_TIME, "rx_got_time_code");
			check_value(rx_tick_out, ev.kind == EV_TIME, "rx_tick_out");
			check_value(err_rise, ev.kind == EV_ERROR, "rx_error rise");
			if (ev.kind == EV_NCHAR)
				check_value(rx_data_flag, ev.value, "rx_data_flag");
			if (ev.kind == EV_TIME)
				check_value(rx_time_out, ev.value[7:0], "rx_time_out");
		end
	endtask

	always @(negedge posedge_clk)
	begin
		if (rx_resetn && (rx_got_fct || rx_got_nchar || rx_got_time_code ||
		    rx_buffer_write || rx_tick_out || (rx_error && !err_seen)))
			compare_event(rx_error && !err_seen);
		err_seen = rx_error;
	end

	// Watchdog bound from the character count
	initial
	begin
		#(WATCHDOG_TIME);
		$display("The simulation ran past its time limit without finishing the tests");
		stop_failed();
	end

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	initial
	begin
		rx_resetn   = 1'b0;
		rx_din      = 1'b0;
		rx_sin      = 1'b0;
		tx_prev_par = 1'b0;
		ref_st      = '0;
		err_seen    = 1'b0;
		rng         = SEED;
		apply_reset();

		// Quiet outputs after reset
		@(negedge posedge_clk);
		check_value({rx_got_fct, rx_got_nchar, rx_got_time_code, rx_buffer_write,
		             rx_tick_out}, 0, "pulse outputs after reset");
		check_value({rx_got_null, rx_got_bit, rx_error}, 0, "levels after reset");
		check_value(rx_time_out, 0, "rx_time_out after reset");

		// Everything before the first NULL is ignored
		send_ctrl(CODE_FCT);
		send_random_data();
		send_random_time();
		wait_drained();
		check_value(rx_got_bit, 1, "rx_got_bit after line activity");
		check_value(rx_got_null, 0, "rx_got_null before NULL");
		send_null();
		wait_drained();
		check_value(rx_got_null, 1, "rx_got_null after NULL");
		send_ctrl(CODE_FCT);
		wait_drained();

		// Data stream with packet ends
		for (int i = 0; i < NUM_BYTES; i++)
		begin
			send_random_data();
			if (i % 8 == 7)
				send_ctrl((i % 16 == 7) ? CODE_EOP : CODE_EEP);
		end
		wait_drained();

		// Time codes
		for (int i = 0; i < NUM_TICKS; i++)
			send_random_time();
		wait_drained();

		// Escape error from ESC then EOP
		apply_reset();
		send_null();
		send_ctrl(CODE_ESC);
		send_ctrl(CODE_EOP);
		for (int i = 0; i < 4; i++)
			send_random_data();
		wait_drained();
		check_value(rx_error, 1, "rx_error after ESC EOP");

		// Parity error in the middle of a stream
		apply_reset();
		send_null();
		for (int i = 0; i < 3; i++)
			send_random_data();
		rng = xorshift32(rng);
		send_char(1'b0, rng[7:0], 1'b1);	// Flipped parity bit
		for (int i = 0; i < 3; i++)
			send_random_data();
		wait_drained();
		check_value(rx_error, 1, "rx_error after parity error");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/spw_rx_pkg.sv
source/spw_ds_decoder.sv
source/spw_char_assembler.sv
source/spw_char_classifier.sv
source/spw_rx.sv
dv/spw_clk_gen.sv
dv/tb_spw_rx.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the SpaceWire receiver testbench with Verilator and runs it.
# Any failed check ends the simulation with $fatal, so the script fails too.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_spw_rx \
	-f filelist.f \
	-o sim_spw_rx

./obj_dir/sim_spw_rx
